// File: Bender.yml
package:
  name: log_req_block

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/log_req_pkg.sv
      - verilog/rr_arbiter.sv
      - verilog/ch_mux2.sv
      - verilog/log_req_block.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/req_checker.sv
      - sim/tb_log_req_block.sv

// File: include/log_req_config.svh
// Build-time sizes for the shared memory request block, included by the package and the top level
`ifndef LOG_REQ_CONFIG_SVH
`define LOG_REQ_CONFIG_SVH

//////////////////////////////////////////////////
// Master counts per channel
//////////////////////////////////////////////////

// Cores on channel 0
`define LOG_N_CH0 4
// DMA ports on channel 1
`define LOG_N_CH1 2

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////

`define LOG_ADDR_WIDTH 32
`define LOG_DATA_WIDTH 32
`define LOG_BE_WIDTH (`LOG_DATA_WIDTH / 8)

// One ID bit per master, cores in the low bits
`define LOG_ID_WIDTH (`LOG_N_CH0 + `LOG_N_CH1)

`endif

// File: log_req_block.f
+incdir+include
verilog/log_req_pkg.sv
verilog/rr_arbiter.sv
verilog/ch_mux2.sv
verilog/log_req_block.sv
sim/req_checker.sv
sim/tb_log_req_block.sv

// File: sim/req_checker.sv
// Reference model and scoreboard that checks the request block ports at every rising clock edge
`timescale 1ns/100ps
`include "log_req_config.svh"

module req_checker (
    input  logic                                      clk,
    input  logic                                      rst_i,

    // Master side of the DUT
    input  logic [`LOG_N_CH0-1:0]                      ch0_req_i,
    input  log_req_pkg::req_payload_t [`LOG_N_CH0-1:0] ch0_data_i,
    input  logic [`LOG_N_CH0-1:0]                      ch0_gnt_i,
    input  logic [`LOG_N_CH1-1:0]                      ch1_req_i,
    input  log_req_pkg::req_payload_t [`LOG_N_CH1-1:0] ch1_data_i,
    input  logic [`LOG_N_CH1-1:0]                      ch1_gnt_i,

    // Memory side of the DUT
    input  logic                                      mem_req_i,
    input  log_req_pkg::req_payload_t                 mem_data_i,
    input  logic                                      mem_gnt_i,
    input  logic                                      mem_r_valid_i,
    input  logic [`LOG_N_CH0-1:0]                      ch0_r_valid_i,
    input  logic [`LOG_N_CH1-1:0]                      ch1_r_valid_i,

    output int unsigned                               error_count_o
);

    localparam int N_CH0 = `LOG_N_CH0;
    localparam int N_CH1 = `LOG_N_CH1;

    //////////////////////////////////////////////////
    // Model state
    //////////////////////////////////////////////////

    int                      last0;
    int                      last1;
    logic                    pref_ch1;
    logic                    prev_xfer;
    log_req_pkg::master_id_t prev_id;
    int unsigned             errors = 0;

    assign error_count_o = errors;

    // First requester after the last winner, wrapping, or -1 if none
    function automatic int next_winner(input logic [31:0] reqs, input int n, input int last);
        int res;
        int idx;

        res = -1;
        for (int k = 1; k <= n; k++)
        begin
            idx = (last + k) % n;
            if (res < 0 && reqs[idx])
            begin
                res = idx;
            end
        end
        return res;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                   input logic [127:0] act_v);
        errors++;
        $display("ERROR at %0t: %s expected %0h actual %0h", $time, name, exp_v, act_v);
    endtask

    //////////////////////////////////////////////////
    // Compare and advance
    //////////////////////////////////////////////////

    always @(posedge clk)
    begin : model
        logic                      any0;
        logic                      any1;
        logic                      sel1;
        logic                      exp_req;
        logic                      xfer;
        int                        w0;
        int                        w1;
        int                        win;
        log_req_pkg::master_id_t   exp_id;
        log_req_pkg::master_id_t   exp_gnt;
        log_req_pkg::master_id_t   exp_rv;
        log_req_pkg::req_payload_t exp_data;

        if (rst_i)
        begin
            last0     = N_CH0 - 1;
            last1     = N_CH1 - 1;
            pref_ch1  = 1'b0;
            prev_xfer = 1'b0;
            prev_id   = '0;
        end
        else
        begin
            any0    = |ch0_req_i;
            any1    = |ch1_req_i;
            w0      = next_winner(32'(ch0_req_i), N_CH0, last0);
            w1      = next_winner(32'(ch1_req_i), N_CH1, last1);
            // DMA wins when alone or when the flag points to it
            if (any0 && any1)
                sel1 = pref_ch1;
            else
                sel1 = any1;
            exp_req = any0 || any1;
            xfer    = exp_req && mem_gnt_i;
            win     = sel1 ? N_CH0 + w1 : w0;

            exp_id   = '0;
            exp_data = '0;
            if (exp_req)
            begin
                exp_id      = log_req_pkg::master_id_t'(1) << win;
                exp_data    = sel1 ? ch1_data_i[w1] : ch0_data_i[w0];
                exp_data.id = exp_id;
            end
            exp_gnt = xfer ? exp_id : '0;
            exp_rv  = prev_xfer ? prev_id : '0;

            if (mem_req_i !== exp_req)
                report_mismatch("data_req_o", 128'(exp_req), 128'(mem_req_i));
            if ({ch1_gnt_i, ch0_gnt_i} !== exp_gnt)
                report_mismatch("ch1_gnt_o,ch0_gnt_o", 128'(exp_gnt), 128'({ch1_gnt_i, ch0_gnt_i}));
            if (exp_req && (mem_data_i !== exp_data))
                report_mismatch("data_o", 128'(exp_data), 128'(mem_data_i));
            if ({ch1_r_valid_i, ch0_r_valid_i} !== exp_rv)
                report_mismatch("ch1_r_valid_o,ch0_r_valid_o", 128'(exp_rv),
                                128'({ch1_r_valid_i, ch0_r_valid_i}));
            if (mem_r_valid_i !== prev_xfer)
            begin
                errors++;
                $display("Memory response valid at %0t does not follow a transfer", $time);
            end

            // Pointer and flag move only on a completed transfer
            prev_xfer = xfer;
            prev_id   = exp_id;
            if (xfer)
            begin
                if (sel1)
                    last1 = w1;
                else
                    last0 = w0;
                pref_ch1 = !sel1;
            end
        end
    end

endmodule

// File: sim/tb_log_req_block.sv
// Testbench top for the request block with random masters, a memory model and a run watchdog
`timescale 1ns/100ps
`include "log_req_config.svh"

module tb_log_req_block;

    localparam int N_CH0           = `LOG_N_CH0;
    localparam int N_CH1           = `LOG_N_CH1;
    localparam int N_MST           = `LOG_ID_WIDTH;
    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 3;
    localparam int RUN_CYCLES      = 2000;
    // Five percent margin over the run
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + RUN_CYCLES / 20;

    logic                                  clk;
    logic                                  rst_i;
    logic [N_MST-1:0]                      mst_req;
    log_req_pkg::req_payload_t [N_MST-1:0] mst_data;
    logic [N_CH0-1:0]                      ch0_gnt;
    logic [N_CH1-1:0]                      ch1_gnt;
    logic                                  data_req;
    log_req_pkg::req_payload_t             mem_data;
    logic                                  data_gnt;
    logic                                  data_r_valid;
    log_req_pkg::master_id_t               data_r_id;
    logic [N_CH0-1:0]                      ch0_r_valid;
    logic [N_CH1-1:0]                      ch1_r_valid;

    // Grants and transfer seen at the last rising edge
    logic [N_MST-1:0]                      gnt_seen;
    logic                                  xfer_seen;
    log_req_pkg::master_id_t               xfer_id;
    integer                                seed;
    int unsigned                           error_count;

    log_req_block dut0 (
        .clk            ( clk                     ),
        .rst_i          ( rst_i                   ),
        .ch0_req_i      ( mst_req[N_CH0-1:0]      ),
        .ch0_data_i     ( mst_data[N_CH0-1:0]     ),
        .ch0_gnt_o      ( ch0_gnt                 ),
        .ch1_req_i      ( mst_req[N_MST-1:N_CH0]  ),
        .ch1_data_i     ( mst_data[N_MST-1:N_CH0] ),
        .ch1_gnt_o      ( ch1_gnt                 ),
        .data_req_o     ( data_req                ),
        .data_o         ( mem_data                ),
        .data_gnt_i     ( data_gnt                ),
        .data_r_valid_i ( data_r_valid            ),
        .data_r_id_i    ( data_r_id               ),
        .ch0_r_valid_o  ( ch0_r_valid             ),
        .ch1_r_valid_o  ( ch1_r_valid             )
    );

    req_checker u_chk (
        .clk           ( clk                     ),
        .rst_i         ( rst_i                   ),
        .ch0_req_i     ( mst_req[N_CH0-1:0]      ),
        .ch0_data_i    ( mst_data[N_CH0-1:0]     ),
        .ch0_gnt_i     ( ch0_gnt                 ),
        .ch1_req_i     ( mst_req[N_MST-1:N_CH0]  ),
        .ch1_data_i    ( mst_data[N_MST-1:N_CH0] ),
        .ch1_gnt_i     ( ch1_gnt                 ),
        .mem_req_i     ( data_req                ),
        .mem_data_i    ( mem_data                ),
        .mem_gnt_i     ( data_gnt                ),
        .mem_r_valid_i ( data_r_valid            ),
        .ch0_r_valid_i ( ch0_r_valid             ),
        .ch1_r_valid_i ( ch1_r_valid             ),
        .error_count_o ( error_count             )
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Random helpers
    //////////////////////////////////////////////////

    function automatic int unsigned roll_percent();
        return $unsigned($random(seed)) % 100;
    endfunction

    // The ID field is random on purpose, the DUT must overwrite it
    function automatic log_req_pkg::req_payload_t random_payload();
        log_req_pkg::req_payload_t pl;

        pl.addr  = $random(seed);
        pl.wen   = 1'($random(seed));
        pl.wdata = $random(seed);
        pl.be    = log_req_pkg::be_t'($random(seed));
        pl.id    = log_req_pkg::master_id_t'($random(seed));
        return pl;
    endfunction

    // Granted masters go idle, idle masters may raise a new request
    task automatic drive_masters();
        for (int m = 0; m < N_MST; m++)
        begin
            if (mst_req[m] && gnt_seen[m])
                mst_req[m] = 1'b0;
            if (!mst_req[m] && roll_percent() < 40)
            begin
                mst_req[m]  = 1'b1;
                mst_data[m] = random_payload();
            end
        end
    endtask

    task automatic drive_memory();
        data_gnt     = (roll_percent() < 70);
        data_r_valid = xfer_seen;
        data_r_id    = xfer_seen ? xfer_id : '0;
    endtask

    //////////////////////////////////////////////////
    // Memory model capture
    //////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (rst_i)
        begin
            gnt_seen  <= '0;
            xfer_seen <= 1'b0;
            xfer_id   <= '0;
        end
        else
        begin
            gnt_seen  <= {ch1_gnt, ch0_gnt};
            xfer_seen <= data_req & data_gnt;
            xfer_id   <= mem_data.id;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial
    begin
        seed         = 96;
        rst_i        = 1'b1;
        mst_req      = '0;
        mst_data     = '0;
        data_gnt     = 1'b0;
        data_r_valid = 1'b0;
        data_r_id    = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_i = 1'b0;
        repeat (RUN_CYCLES)
        begin
            @(negedge clk);
            drive_masters();
            drive_memory();
        end
        @(negedge clk);
        $display("Run finished after %0d cycles with %0d errors", RUN_CYCLES, error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: verilog/ch_mux2.sv
// Round-robin selector between the core channel and the DMA channel in front of the memory port
`timescale 1ns/100ps

module ch_mux2 (
    input  logic                      clk,
    input  logic                      rst_i,

    // Channel 0, cores
    input  logic                      ch0_req_i,
    input  log_req_pkg::req_payload_t ch0_data_i,
    output logic                      ch0_gnt_o,

    // Channel 1, DMA
    input  logic                      ch1_req_i,
    input  log_req_pkg::req_payload_t ch1_data_i,
    output logic                      ch1_gnt_o,

    // Memory side
    output logic                      req_o,
    output log_req_pkg::req_payload_t data_o,
    input  logic                      gnt_i
);

    //////////////////////////////////////////////////
    // Selection
    //////////////////////////////////////////////////

    // Preferred channel on a tie, 0 for cores and 1 for DMA
    logic pref_q;
    logic sel_ch1;
    logic xfer;

    // A lone requester always wins, the flag only breaks ties
    assign sel_ch1 = ch1_req_i & (~ch0_req_i | pref_q);

    assign req_o  = ch0_req_i | ch1_req_i;
    assign data_o = sel_ch1 ? ch1_data_i : ch0_data_i;

    // Memory grant is steered to the selected channel only
    assign ch0_gnt_o = gnt_i & ch0_req_i & ~sel_ch1;
    assign ch1_gnt_o = gnt_i & sel_ch1;

    assign xfer = req_o & gnt_i;

    //////////////////////////////////////////////////
    // Preference flag
    //////////////////////////////////////////////////

    // After each transfer the flag moves to the channel that lost
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            pref_q <= 1'b0;
        end
        else if (xfer)
        begin
            pref_q <= ~sel_ch1;
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////

    // Only one channel may be handed the memory grant
    ch_gnt_excl_a : assert property (
        @(posedge clk) disable iff (rst_i)
        !(ch0_gnt_o && ch1_gnt_o)
    ) else $error("ch_mux2: both channel grants high");

endmodule

// File: verilog/log_req_block.sv
// Top of the shared memory request block, arbitrating cores and DMA and routing response valids back
`timescale 1ns/100ps
`include "log_req_config.svh"

module log_req_block (
    input  logic                                     clk,
    input  logic                                     rst_i,

    // Channel 0, cores
    input  logic [`LOG_N_CH0-1:0]                     ch0_req_i,
    input  log_req_pkg::req_payload_t [`LOG_N_CH0-1:0] ch0_data_i,
    output logic [`LOG_N_CH0-1:0]                     ch0_gnt_o,

    // Channel 1, DMA
    input  logic [`LOG_N_CH1-1:0]                     ch1_req_i,
    input  log_req_pkg::req_payload_t [`LOG_N_CH1-1:0] ch1_data_i,
    output logic [`LOG_N_CH1-1:0]                     ch1_gnt_o,

    // Request toward memory
    output logic                                     data_req_o,
    output log_req_pkg::req_payload_t                data_o,
    input  logic                                     data_gnt_i,

    // Response from memory
    input  logic                                     data_r_valid_i,
    input  log_req_pkg::master_id_t                  data_r_id_i,

    // Response valids back to the masters
    output logic [`LOG_N_CH0-1:0]                     ch0_r_valid_o,
    output logic [`LOG_N_CH1-1:0]                     ch1_r_valid_o
);

    localparam int unsigned N_CH0 = `LOG_N_CH0;
    localparam int unsigned N_CH1 = `LOG_N_CH1;
    localparam int unsigned ID_W  = `LOG_ID_WIDTH;

    //////////////////////////////////////////////////
    // ID stamping
    //////////////////////////////////////////////////

    // Replace whatever ID the master sent with its own one-hot bit
    function automatic log_req_pkg::req_payload_t stamp_id(
        input log_req_pkg::req_payload_t pl,
        input int unsigned               pos
    );
        log_req_pkg::req_payload_t res;

        res    = pl;
        res.id = log_req_pkg::master_id_t'(1) << pos;
        return res;
    endfunction

    log_req_pkg::req_payload_t [N_CH0-1:0] ch0_stamped;
    log_req_pkg::req_payload_t [N_CH1-1:0] ch1_stamped;

    // Cores take the low ID bits
    for (genvar i = 0; i < N_CH0; i++)
    begin : g_ch0_stamp
        assign ch0_stamped[i] = stamp_id(ch0_data_i[i], i);
    end

    // DMA bits follow right after the cores
    for (genvar j = 0; j < N_CH1; j++)
    begin : g_ch1_stamp
        assign ch1_stamped[j] = stamp_id(ch1_data_i[j], N_CH0 + j);
    end

    //////////////////////////////////////////////////
    // Per-channel arbitration
    //////////////////////////////////////////////////

    logic                      ch0_req;
    log_req_pkg::req_payload_t ch0_data;
    logic                      ch0_gnt;

    logic                      ch1_req;
    log_req_pkg::req_payload_t ch1_data;
    logic                      ch1_gnt;

    rr_arbiter #(
        .N_MASTER ( N_CH0 )
    ) u_arb_ch0 (
        .clk    ( clk         ),
        .rst_i  ( rst_i       ),
        .req_i  ( ch0_req_i   ),
        .data_i ( ch0_stamped ),
        .gnt_o  ( ch0_gnt_o   ),
        .req_o  ( ch0_req     ),
        .data_o ( ch0_data    ),
        .gnt_i  ( ch0_gnt     )
    );

    rr_arbiter #(
        .N_MASTER ( N_CH1 )
    ) u_arb_ch1 (
        .clk    ( clk         ),
        .rst_i  ( rst_i       ),
        .req_i  ( ch1_req_i   ),
        .data_i ( ch1_stamped ),
        .gnt_o  ( ch1_gnt_o   ),
        .req_o  ( ch1_req     ),
        .data_o ( ch1_data    ),
        .gnt_i  ( ch1_gnt     )
    );

    //////////////////////////////////////////////////
    // Channel selection
    //////////////////////////////////////////////////

    ch_mux2 u_ch_mux (
        .clk        ( clk        ),
        .rst_i      ( rst_i      ),
        .ch0_req_i  ( ch0_req    ),
        .ch0_data_i ( ch0_data   ),
        .ch0_gnt_o  ( ch0_gnt    ),
        .ch1_req_i  ( ch1_req    ),
        .ch1_data_i ( ch1_data   ),
        .ch1_gnt_o  ( ch1_gnt    ),
        .req_o      ( data_req_o ),
        .data_o     ( data_o     ),
        .gnt_i      ( data_gnt_i )
    );

    //////////////////////////////////////////////////
    // Response routing
    //////////////////////////////////////////////////

    // The one-hot ID already is the per-master valid vector
    logic [ID_W-1:0] r_valid_all;

    assign r_valid_all   = data_r_valid_i ? data_r_id_i : '0;
    assign ch0_r_valid_o = r_valid_all[N_CH0-1:0];
    assign ch1_r_valid_o = r_valid_all[ID_W-1:N_CH0];

    //////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////

    // Memory must return exactly one master ID with each response
    r_id_onehot_a : assert property (
        @(posedge clk) disable iff (rst_i)
        data_r_valid_i |-> $onehot(data_r_id_i)
    ) else $error("log_req_block: response ID not one-hot");

endmodule

// File: verilog/log_req_pkg.sv
// Request payload and master ID types shared by the request block RTL and its testbench
`include "log_req_config.svh"

package log_req_pkg;

    //////////////////////////////////////////////////
    // Field types
    //////////////////////////////////////////////////

    typedef logic [`LOG_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`LOG_DATA_WIDTH-1:0] data_t;
    typedef logic [`LOG_BE_WIDTH-1:0]   be_t;

    // One-hot master ID
    // Bits 0 .. N_CH0-1 are the cores, the DMA masters sit above them
    typedef logic [`LOG_ID_WIDTH-1:0]   master_id_t;

    //////////////////////////////////////////////////
    // Request payload
    //////////////////////////////////////////////////

    // Everything that travels with a request toward memory
    // wen is active low, so 0 means write and 1 means read
    typedef struct packed {
        addr_t      addr;
        logic       wen;
        data_t      wdata;
        be_t        be;
        master_id_t id;
    } req_payload_t;

endpackage

// File: verilog/rr_arbiter.sv
// Flat round-robin arbiter that merges the requesters of one channel into a single request
`timescale 1ns/100ps

module rr_arbiter #(
    parameter int unsigned N_MASTER = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_i,

    // Master side
    input  logic [N_MASTER-1:0]                     req_i,
    input  log_req_pkg::req_payload_t [N_MASTER-1:0] data_i,
    output logic [N_MASTER-1:0]                     gnt_o,

    // Toward the channel selector
    output logic                                    req_o,
    output log_req_pkg::req_payload_t               data_o,
    input  logic                                    gnt_i
);

    // Pointer needs at least one bit even for a single master
    localparam int unsigned PTR_W = (N_MASTER > 1) ? $clog2(N_MASTER) : 1;

    //////////////////////////////////////////////////
    // State and winner signals
    //////////////////////////////////////////////////

    // Index of the master that won the last completed transfer
    logic [PTR_W-1:0] last_q;

    logic [PTR_W-1:0] win_idx;
    logic             win_found;
    logic             xfer;

    //////////////////////////////////////////////////
    // Winner search
    //////////////////////////////////////////////////

    // Scan starts one past the last winner and wraps around, so the
    // last winner itself is checked at the very end
    always_comb
    begin : search
        int unsigned idx;

        win_idx   = last_q;
        win_found = 1'b0;

        for (int unsigned k = 1; k <= N_MASTER; k++)
        begin
            idx = int'(last_q) + k;
            if (idx >= N_MASTER)
            begin
                idx = idx - N_MASTER;
            end
            if (!win_found && req_i[idx])
            begin
                win_found = 1'b1;
                win_idx   = PTR_W'(idx);
            end
        end
    end

    //////////////////////////////////////////////////
    // Request, payload and grant
    //////////////////////////////////////////////////

    assign req_o = |req_i;

    // With no request the payload is don't care, the pointer entry is fine
    assign data_o = data_i[win_idx];

    // Grant goes back only to the winner and only when downstream accepts
    always_comb
    begin
        gnt_o = '0;
        if (win_found)
        begin
            gnt_o[win_idx] = gnt_i;
        end
    end

    assign xfer = req_o & gnt_i;

    //////////////////////////////////////////////////
    // Last-winner pointer
    //////////////////////////////////////////////////

    // Starts at the top index so master 0 is first in line after reset
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            last_q <= PTR_W'(N_MASTER - 1);
        end
        else if (xfer)
        begin
            last_q <= win_idx;
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////

    // At most one master of the channel is granted in any cycle
    gnt_onehot_a : assert property (
        @(posedge clk) disable iff (rst_i)
        $onehot0(gnt_o)
    ) else $error("rr_arbiter: more than one grant high");

    // A grant never reaches a master that is not requesting
    gnt_has_req_a : assert property (
        @(posedge clk) disable iff (rst_i)
        (gnt_o & ~req_i) == '0
    ) else $error("rr_arbiter: grant to an idle master");

    // A master held off by back-pressure keeps winning until it is served
    hold_winner_a : assert property (
        @(posedge clk) disable iff (rst_i)
        (req_o && !gnt_i && ((req_i & ~$past(req_i)) == '0) && $past(req_o) && !$past(gnt_i))
            |-> (win_idx == $past(win_idx))
    ) else $error("rr_arbiter: winner moved under back-pressure");

endmodule
